// File: ringPkg.sv
/*
 * shared types for the bidirectional ring switch
 * node-ID and payload widths, flit and link structs,
 * inject routing decision and eject round-robin state
 */
package ringPkg;

	// node IDs fit up to 8 nodes on the ring
	localparam int NodeIdW = 3;

	// payload carried untouched from inject to eject
	localparam int PayloadW = 32;

	// one packet on the ring
	// dst picks the eject port, src travels along for the receiver
	typedef struct packed {
		logic [NodeIdW-1:0]  dst;
		logic [NodeIdW-1:0]  src;
		logic [PayloadW-1:0] payload;
	} ringFlit_t;

	// data plus send strobe, same shape on every path
	// ring links, inject, eject and FIFO heads
	// send high means flit is valid this cycle
	typedef struct packed {
		logic      send;
		ringFlit_t flit;
	} ringLink_t;

	// where an injected flit goes
	// eject when addressed to own node
	// otherwise the shorter way round, ties go clockwise
	typedef enum logic [1:0] {
		DirEject = 2'd0,
		DirCw    = 2'd1,
		DirCcw   = 2'd2
	} routeDir_e;

	// which ring input has first claim on the eject port
	// toggles to the other side after a ring eject
	typedef enum logic {
		SelCw  = 1'b0,
		SelCcw = 1'b1
	} ejectSel_e;

endpackage

// File: linkFifo.sv
/*
 * linkFifo
 * circular flit buffer for one router input
 * slotAvail from occupancy only, head presented with send = not empty
 */
module linkFifo #(
	parameter int fifoDepth = 4
) (
	input  logic               clk,
	input  logic               arstN,
	input  ringPkg::ringLink_t pushLink,
	output logic               slotAvail,
	output ringPkg::ringLink_t head,
	input  logic               pop
);
	import ringPkg::*;

	// pointer width, at least one bit for a single-entry FIFO
	localparam int AddrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int CountW = $clog2(fifoDepth + 1);
	localparam logic [AddrW-1:0] LastAddr = AddrW'(fifoDepth - 1);
	localparam logic [CountW-1:0] FullCount = CountW'(fifoDepth);

	ringFlit_t         mem [fifoDepth];
	logic [AddrW-1:0]  wrPtr;
	logic [AddrW-1:0]  rdPtr;
	logic [CountW-1:0] count;
	logic              doPush;
	logic              doPop;

	// sender only raises send while slotAvail is high
	assign doPush = pushLink.send;
	// pop on empty is ignored
	assign doPop = pop && (count != '0);

	// registered occupancy only, nothing from send feeds back here
	assign slotAvail = (count != FullCount);

	assign head.send = (count != '0);
	assign head.flit = mem[rdPtr];

	// storage, written on accepted push
	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushLink.flit;
	end

	// pointers and occupancy
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == LastAddr) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == LastAddr) ? '0 : rdPtr + 1'b1;
			// simultaneous push and pop keeps the count
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

// File: nodeArbiter.sv
/*
 * nodeArbiter
 * routing of the inject head by modular ring distance
 * grants of cw, ccw and inject heads onto cw, ccw and eject outputs
 * eject round-robin between the two ring inputs
 */
module nodeArbiter #(
	parameter int numNodes = 7,
	parameter int nodeId = 0
) (
	input  logic               clk,
	input  logic               arstN,
	input  ringPkg::ringLink_t cwHead,
	input  ringPkg::ringLink_t ccwHead,
	input  ringPkg::ringLink_t injHead,
	input  logic               cwSlotAvail,
	input  logic               ccwSlotAvail,
	input  logic               ejectSlotAvail,
	output logic               cwPop,
	output logic               ccwPop,
	output logic               injPop,
	output ringPkg::ringLink_t cwOut,
	output ringPkg::ringLink_t ccwOut,
	output ringPkg::ringLink_t ejectOut
);
	import ringPkg::*;

	// one extra bit so dst + ring size never wraps
	localparam logic [NodeIdW:0] RingSize = (NodeIdW + 1)'(numNodes);
	localparam logic [NodeIdW:0] MyId = (NodeIdW + 1)'(nodeId);

	logic             cwWantEject;
	logic             cwWantFwd;
	logic             ccwWantEject;
	logic             ccwWantFwd;
	logic [NodeIdW:0] cwDist;
	logic [NodeIdW:0] ccwDist;
	routeDir_e        injDir;
	ejectSel_e        rrSel;
	logic             cwEjGrant;
	logic             ccwEjGrant;
	logic             injEjGrant;
	logic             cwFwdGrant;
	logic             ccwFwdGrant;
	logic             injCwGrant;
	logic             injCcwGrant;

	// ring heads either leave here or keep going their own way
	assign cwWantEject = cwHead.send && ({1'b0, cwHead.flit.dst} == MyId);
	assign cwWantFwd = cwHead.send && !cwWantEject;
	assign ccwWantEject = ccwHead.send && ({1'b0, ccwHead.flit.dst} == MyId);
	assign ccwWantFwd = ccwHead.send && !ccwWantEject;

	// shortest direction for the inject head
	always_comb begin
		cwDist = {1'b0, injHead.flit.dst} + RingSize - MyId;
		if (cwDist >= RingSize)
			cwDist = cwDist - RingSize;
		ccwDist = RingSize - cwDist;
		if ({1'b0, injHead.flit.dst} == MyId)
			injDir = DirEject;
		else if (cwDist <= ccwDist)
			injDir = DirCw;
		else
			injDir = DirCcw;
	end

	// eject port, ring inputs first, inject only when both are quiet
	always_comb begin
		cwEjGrant = 1'b0;
		ccwEjGrant = 1'b0;
		injEjGrant = 1'b0;
		if (ejectSlotAvail) begin
			if (cwWantEject && ccwWantEject) begin
				// both ring sides compete, round-robin decides
				cwEjGrant = (rrSel == SelCw);
				ccwEjGrant = (rrSel == SelCcw);
			end else if (cwWantEject) begin
				cwEjGrant = 1'b1;
			end else if (ccwWantEject) begin
				ccwEjGrant = 1'b1;
			end else begin
				injEjGrant = injHead.send && (injDir == DirEject);
			end
		end
	end

	// ring outputs, through traffic beats injected traffic
	assign cwFwdGrant = cwWantFwd && cwSlotAvail;
	assign ccwFwdGrant = ccwWantFwd && ccwSlotAvail;
	assign injCwGrant = injHead.send && (injDir == DirCw) && cwSlotAvail && !cwWantFwd;
	assign injCcwGrant = injHead.send && (injDir == DirCcw) && ccwSlotAvail && !ccwWantFwd;

	// a head leaves its FIFO at the edge where it is granted
	assign cwPop = cwEjGrant || cwFwdGrant;
	assign ccwPop = ccwEjGrant || ccwFwdGrant;
	assign injPop = injEjGrant || injCwGrant || injCcwGrant;

	// output muxes
	assign cwOut.send = cwFwdGrant || injCwGrant;
	assign cwOut.flit = cwFwdGrant ? cwHead.flit : injHead.flit;
	assign ccwOut.send = ccwFwdGrant || injCcwGrant;
	assign ccwOut.flit = ccwFwdGrant ? ccwHead.flit : injHead.flit;
	assign ejectOut.send = cwEjGrant || ccwEjGrant || injEjGrant;
	always_comb begin
		if (ccwEjGrant)
			ejectOut.flit = ccwHead.flit;
		else if (injEjGrant)
			ejectOut.flit = injHead.flit;
		else
			ejectOut.flit = cwHead.flit;
	end

	// other ring side gets first claim after a ring eject
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			rrSel <= SelCw;
		else if (cwEjGrant)
			rrSel <= SelCcw;
		else if (ccwEjGrant)
			rrSel <= SelCw;
	end

endmodule

// File: ringRouter.sv
/*
 * ringRouter
 * one ring node, cw, ccw and inject input FIFOs
 * feeding the node arbiter
 */
module ringRouter #(
	parameter int numNodes = 7,
	parameter int nodeId = 0,
	parameter int fifoDepth = 4
) (
	input  logic               clk,
	input  logic               arstN,
	input  ringPkg::ringLink_t cwIn,
	output logic               cwInSlotAvail,
	input  ringPkg::ringLink_t ccwIn,
	output logic               ccwInSlotAvail,
	input  ringPkg::ringLink_t injectLink,
	output logic               injectSlotAvail,
	output ringPkg::ringLink_t cwOut,
	input  logic               cwOutSlotAvail,
	output ringPkg::ringLink_t ccwOut,
	input  logic               ccwOutSlotAvail,
	output ringPkg::ringLink_t ejectLink,
	input  logic               ejectSlotAvail
);
	import ringPkg::*;

	// FIFO heads and pops between buffers and arbiter
	ringLink_t cwHead;
	ringLink_t ccwHead;
	ringLink_t injHead;
	logic      cwPop;
	logic      ccwPop;
	logic      injPop;

	// from upstream cw neighbour
	linkFifo #(.fifoDepth(fifoDepth)) cwFifo (
		.clk(clk),
		.arstN(arstN),
		.pushLink(cwIn),
		.slotAvail(cwInSlotAvail),
		.head(cwHead),
		.pop(cwPop)
	);

	// from upstream ccw neighbour
	linkFifo #(.fifoDepth(fifoDepth)) ccwFifo (
		.clk(clk),
		.arstN(arstN),
		.pushLink(ccwIn),
		.slotAvail(ccwInSlotAvail),
		.head(ccwHead),
		.pop(ccwPop)
	);

	// external traffic entering at this node
	linkFifo #(.fifoDepth(fifoDepth)) injFifo (
		.clk(clk),
		.arstN(arstN),
		.pushLink(injectLink),
		.slotAvail(injectSlotAvail),
		.head(injHead),
		.pop(injPop)
	);

	nodeArbiter #(
		.numNodes(numNodes),
		.nodeId(nodeId)
	) arbiter0 (
		.clk(clk),
		.arstN(arstN),
		.cwHead(cwHead),
		.ccwHead(ccwHead),
		.injHead(injHead),
		.cwSlotAvail(cwOutSlotAvail),
		.ccwSlotAvail(ccwOutSlotAvail),
		.ejectSlotAvail(ejectSlotAvail),
		.cwPop(cwPop),
		.ccwPop(ccwPop),
		.injPop(injPop),
		.cwOut(cwOut),
		.ccwOut(ccwOut),
		.ejectOut(ejectLink)
	);

endmodule

// File: ringSwitch.sv
/*
 * ringSwitch
 * top level, numNodes routers on a bidirectional ring
 * cw links run node i to i+1, ccw links node i to i-1
 */
module ringSwitch #(
	parameter int numNodes = 7,
	parameter int fifoDepth = 4
) (
	input  logic                clk,
	input  logic                arstN,
	input  ringPkg::ringLink_t  injectLink [numNodes],
	output logic [numNodes-1:0] injectSlotAvail,
	output ringPkg::ringLink_t  ejectLink [numNodes],
	input  logic [numNodes-1:0] ejectSlotAvail
);
	import ringPkg::*;

	// cwLink[i] and ccwLink[i] are driven by node i
	ringLink_t           cwLink [numNodes];
	ringLink_t           ccwLink [numNodes];
	// cwSlot[i] and ccwSlot[i] come from node i input FIFOs
	logic [numNodes-1:0] cwSlot;
	logic [numNodes-1:0] ccwSlot;

	for (genvar i = 0; i < numNodes; i++) begin : nodeGen
		// ring neighbours, modular in both directions
		localparam int Prev = (i + numNodes - 1) % numNodes;
		localparam int Next = (i + 1) % numNodes;

		ringRouter #(
			.numNodes(numNodes),
			.nodeId(i),
			.fifoDepth(fifoDepth)
		) router0 (
			.clk(clk),
			.arstN(arstN),
			// cw traffic arrives from the previous node
			.cwIn(cwLink[Prev]),
			.cwInSlotAvail(cwSlot[i]),
			// ccw traffic arrives from the next node
			.ccwIn(ccwLink[Next]),
			.ccwInSlotAvail(ccwSlot[i]),
			.injectLink(injectLink[i]),
			.injectSlotAvail(injectSlotAvail[i]),
			.cwOut(cwLink[i]),
			.cwOutSlotAvail(cwSlot[Next]),
			.ccwOut(ccwLink[i]),
			.ccwOutSlotAvail(ccwSlot[Prev]),
			.ejectLink(ejectLink[i]),
			.ejectSlotAvail(ejectSlotAvail[i])
		);
	end

endmodule

// File: ringSwitchTb.sv
/*
 * testbench for the ring switch
 * clock, reset, LCG, inject tasks, scoreboard with latency records,
 * concurrent and immediate checks, cycle watchdog, closing report
 */
module ringSwitchTb;
	import ringPkg::*;

	localparam int NumNodes = 7;
	localparam int RandCycles = 1500;
	// idle sweep, two stall tests, random phase and drains
	localparam int MaxCycles = 2 * RandCycles + NumNodes * NumNodes * 20;

	// one outstanding flit
	// expLat of 0 means no latency check
	typedef struct packed {
		logic [NodeIdW-1:0]  src;
		logic [NodeIdW-1:0]  dst;
		logic [PayloadW-1:0] payload;
		int                  acceptCycle;
		int                  expLat;
	} sbEntry_t;

	logic                clk = 1'b0;
	logic                arstN = 1'b0;
	ringLink_t           injectLink [NumNodes];
	logic [NumNodes-1:0] injectSlotAvail;
	ringLink_t           ejectLink [NumNodes];
	logic [NumNodes-1:0] ejectSlotAvail;

	sbEntry_t    sbQ [$];
	int          cycle = 0;
	int          dataErrs = 0;
	int          protoErrs = 0;
	int          otherErrs = 0;
	bit          injStarted = 1'b0;
	bit          checkLatency = 1'b0;
	logic [31:0] lcgState = 32'hbb4843a5;

	ringSwitch #(.numNodes(NumNodes), .fifoDepth(4)) dut0 (
		.clk(clk),
		.arstN(arstN),
		.injectLink(injectLink),
		.injectSlotAvail(injectSlotAvail),
		.ejectLink(ejectLink),
		.ejectSlotAvail(ejectSlotAvail)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// hop count along the shorter way round
	function automatic int hopDist(input int src, input int dst);
		int cw;
		cw = (dst - src + NumNodes) % NumNodes;
		return (cw <= NumNodes - cw) ? cw : NumNodes - cw;
	endfunction

	function automatic ringLink_t makeLink(input int src, input int dst,
			input logic [PayloadW-1:0] payload);
		ringLink_t l;
		l.send = 1'b1;
		l.flit.dst = NodeIdW'(dst);
		l.flit.src = NodeIdW'(src);
		l.flit.payload = payload;
		return l;
	endfunction

	// index of the oldest outstanding flit of this pair or -1
	function automatic int findExpected(input int src, input int dst);
		for (int i = 0; i < sbQ.size(); i++) begin
			if (sbQ[i].src == NodeIdW'(src) && sbQ[i].dst == NodeIdW'(dst))
				return i;
		end
		return -1;
	endfunction

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	// waits for a free slot, then drives send for one cycle
	task automatic injectOne(input int src, input int dst, input logic [PayloadW-1:0] payload);
		while (!injectSlotAvail[src])
			stepCycle();
		injStarted = 1'b1;
		injectLink[src] = makeLink(src, dst, payload);
		stepCycle();
		injectLink[src].send = 1'b0;
	endtask

	task automatic waitDrain(input int limit);
		int waited;
		waited = 0;
		while (sbQ.size() != 0 && waited < limit) begin
			stepCycle();
			waited++;
		end
		// late duplicates would show up here
		repeat (4) stepCycle();
		drainCheck: assert (sbQ.size() == 0) else begin
			$display("%0d flits were never delivered after %0d drain cycles", sbQ.size(), limit);
			otherErrs++;
		end
	endtask

	task automatic finishRun(input bit timedOut);
		$display("errors: data %0d, protocol %0d, other %0d, timeout %0d",
			dataErrs, protoErrs, otherErrs, timedOut);
		if (timedOut || dataErrs + protoErrs + otherErrs != 0) begin
			$display("Result: FAILED");
		end else begin
			$display("Result: PASSED");
		end
		$finish;
	endtask

	// per-port protocol rules
	for (genvar n = 0; n < NumNodes; n++) begin : portChecks
		ejectHoldCheck: assert property (@(posedge clk) disable iff (!arstN)
			!ejectSlotAvail[n] |-> !ejectLink[n].send)
			else begin
				$display("ERR t=%0t ejectLink[%0d].send exp=0 got=1", $time, n);
				protoErrs++;
			end
		ejectDstCheck: assert property (@(posedge clk) disable iff (!arstN)
			ejectLink[n].send |-> ejectLink[n].flit.dst == n)
			else begin
				$display("ERR t=%0t ejectLink[%0d].flit.dst exp=%0d got=%0d",
					$time, n, n, ejectLink[n].flit.dst);
				dataErrs++;
			end
		// quiet ring until the first flit goes in
		idleEjectCheck: assert property (@(posedge clk) disable iff (!arstN)
			!injStarted |-> !ejectLink[n].send)
			else begin
				$display("ERR t=%0t ejectLink[%0d].send exp=0 got=1", $time, n);
				protoErrs++;
			end
		idleSlotCheck: assert property (@(posedge clk) disable iff (!arstN)
			!injStarted |-> injectSlotAvail[n])
			else begin
				$display("ERR t=%0t injectSlotAvail[%0d] exp=1 got=0", $time, n);
				protoErrs++;
			end
	end

	// ejects are matched before this edge's accepts are queued
	always @(posedge clk) begin : scoreboardMon
		int idx;
		sbEntry_t e;
		ringFlit_t f;
		if (arstN) begin
			for (int n = 0; n < NumNodes; n++) begin
				if (ejectLink[n].send) begin
					f = ejectLink[n].flit;
					idx = findExpected(int'(f.src), n);
					matchCheck: assert (idx >= 0) else begin
						$display("flit from node %0d ejected at node %0d was never expected",
							f.src, n);
						otherErrs++;
					end
					if (idx >= 0) begin
						e = sbQ[idx];
						payloadCheck: assert (f.payload == e.payload) else begin
							$display("ERR t=%0t ejectLink[%0d].flit.payload exp=%h got=%h",
								$time, n, e.payload, f.payload);
							dataErrs++;
						end
						if (e.expLat > 0) begin
							latencyCheck: assert (cycle - e.acceptCycle == e.expLat) else begin
								$display("ERR t=%0t ejectLink[%0d] latency exp=%0d got=%0d",
									$time, n, e.expLat, cycle - e.acceptCycle);
								dataErrs++;
							end
						end
						sbQ.delete(idx);
					end
				end
			end
			for (int n = 0; n < NumNodes; n++) begin
				if (injectLink[n].send && injectSlotAvail[n]) begin
					e.src = NodeIdW'(n);
					e.dst = injectLink[n].flit.dst;
					e.payload = injectLink[n].flit.payload;
					e.acceptCycle = cycle;
					e.expLat = checkLatency ? hopDist(n, int'(e.dst)) + 1 : 0;
					sbQ.push_back(e);
				end
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycle <= cycle + 1;
		if (cycle >= MaxCycles) begin
			$display("timeout, the run did not finish within %0d cycles", MaxCycles);
			finishRun(1'b1);
		end
	end

	initial begin : stimulus
		int sent;
		logic [31:0] r;
		int srcList [4];
		srcList = '{0, 1, 5, 6};
		for (int n = 0; n < NumNodes; n++)
			injectLink[n] = '0;
		ejectSlotAvail = '1;
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;
		// quiet cycles after reset
		repeat (5) stepCycle();

		// every pair on an idle ring with exact latency
		checkLatency = 1'b1;
		for (int s = 0; s < NumNodes; s++) begin
			for (int d = 0; d < NumNodes; d++) begin
				injectOne(s, d, nextRand());
				waitDrain(NumNodes + 4);
			end
		end
		checkLatency = 1'b0;

		// stalled eject at node 3 fed from both ring sides
		ejectSlotAvail[3] = 1'b0;
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 4; i++)
				injectOne(srcList[i], 3, nextRand());
		end
		repeat (20) stepCycle();
		ejectSlotAvail[3] = 1'b1;
		waitDrain(60);

		// back-pressure all the way to the inject port of node 5
		ejectSlotAvail[2] = 1'b0;
		sent = 0;
		while (injectSlotAvail[5] && sent < 40) begin
			injectOne(5, 2, nextRand());
			sent++;
		end
		backPressCheck: assert (!injectSlotAvail[5]) else begin
			$display("inject slot at node 5 stayed free after %0d flits", sent);
			otherErrs++;
		end
		repeat (10) stepCycle();
		ejectSlotAvail[2] = 1'b1;
		waitDrain(80);

		// random traffic on all nodes
		for (int c = 0; c < RandCycles; c++) begin
			for (int n = 0; n < NumNodes; n++) begin
				r = nextRand();
				if (injectSlotAvail[n] && r[31])
					injectLink[n] = makeLink(n, int'(r[23:16]) % NumNodes, nextRand());
				else
					injectLink[n].send = 1'b0;
				// about one cycle in four refused
				ejectSlotAvail[n] = (r[9:8] != 2'b00);
			end
			stepCycle();
		end
		for (int n = 0; n < NumNodes; n++)
			injectLink[n].send = 1'b0;
		ejectSlotAvail = '1;
		waitDrain(200);

		finishRun(1'b0);
	end

endmodule

// File: vlog.f
ringPkg.sv
linkFifo.sv
nodeArbiter.sv
ringRouter.sv
ringSwitch.sv
ringSwitchTb.sv

// File: Makefile
# Verilator build and run for the ring switch testbench

VERILATOR ?= verilator
TOP       ?= ringSwitchTb
FILELIST  ?= vlog.f
LOGFILE   ?= sim.log
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASSMSG := Result: PASSED
SRCS    := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOGFILE)
	@grep -qFx "$(PASSMSG)" $(LOGFILE) || \
		(echo "simulation failed, see $(LOGFILE)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOGFILE)
